// File: run.sh
#!/usr/bin/env bash
# compile with Verilator and run, exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_zx_pager -o sim_zx_pager \
	&& ./obj_dir/sim_zx_pager \
	|| { echo "build or simulation returned an error"; exit 1; }

// File: source/pager_bank.sv
`timescale 1ns/1ps
`include "zx_params.svh"

module pager_bank (
	input  logic                    fclk,
	input  logic                    rst_n,

	input  zx_pkg::req_kind_t       dec_kind,
	input  zx_pkg::win_t            dec_win,
	input  logic [`ZX_OFS_W-1:0]    dec_ofs,
	input  logic [`ZX_DATA_W-1:0]   dec_data,

	output logic                    ex_valid,
	output logic                    ex_rom,
	output logic [`ZX_PAGE_W-1:0]   ex_page,
	output logic [`ZX_OFS_W-1:0]    ex_ofs,

	output logic [`ZX_BORDER_W-1:0] border,
	output logic                    beep
);

	// 7FFD fields
	logic [2:0] bank_7ffd;
	logic       rom_sel;
	logic       lock_7ffd;

	// ATM window pagers
	logic [`ZX_PAGE_W-1:0] win_page [4];
	logic [3:0]            win_ram;
	logic                  pager_en;

	logic                  sel_rom;
	logic [`ZX_PAGE_W-1:0] sel_page;

	////////////////////////////////////////
	// port state
	////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bank_7ffd <= '0;
			rom_sel   <= 1'b0;
			lock_7ffd <= 1'b0;
			pager_en  <= 1'b0;
			win_ram   <= '0;
			border    <= '0;
			beep      <= 1'b0;
			for (int i = 0; i < 4; i++)
				win_page[i] <= '0;
		end
		else
		begin
			case (dec_kind)
				zx_pkg::req_7ffd:
				begin
					// once locked only reset frees the port
					if (!lock_7ffd)
					begin
						bank_7ffd <= dec_data[2:0];
						rom_sel   <= dec_data[4];
						lock_7ffd <= dec_data[5];
					end
				end
				zx_pkg::req_f7:
				begin
					win_page[dec_win] <= dec_data[`ZX_PAGE_W-1:0];
					win_ram[dec_win]  <= dec_data[7];
				end
				zx_pkg::req_77:
					pager_en <= dec_data[0];
				zx_pkg::req_fe:
				begin
					border <= dec_data[`ZX_BORDER_W-1:0];
					beep   <= dec_data[4];
				end
				default:
				begin
				end
			endcase
		end
	end

	////////////////////////////////////////
	// page selection for a lookup
	////////////////////////////////////////

	always_comb
	begin
		if (pager_en)
		begin
			sel_page = win_page[dec_win];
			sel_rom  = ~win_ram[dec_win];
		end
		else
		begin
			// classic pentagon layout
			case (dec_win)
				2'd0:
				begin
					sel_page = `ZX_PAGE_W'(rom_sel);
					sel_rom  = 1'b1;
				end
				2'd1:
				begin
					sel_page = `ZX_PAGE_W'(`ZX_PENT_WIN1_PAGE);
					sel_rom  = 1'b0;
				end
				2'd2:
				begin
					sel_page = `ZX_PAGE_W'(`ZX_PENT_WIN2_PAGE);
					sel_rom  = 1'b0;
				end
				default:
				begin
					sel_page = `ZX_PAGE_W'(bank_7ffd);
					sel_rom  = 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			ex_valid <= 1'b0;
		else
			ex_valid <= (dec_kind == zx_pkg::req_mem);
	end

	always_ff @(posedge fclk)
	begin
		if (dec_kind == zx_pkg::req_mem)
		begin
			ex_rom  <= sel_rom;
			ex_page <= sel_page;
			ex_ofs  <= dec_ofs;
		end
	end

endmodule

// File: source/phys_map.sv
`timescale 1ns/1ps
`include "zx_params.svh"

module phys_map (
	input  logic                  fclk,
	input  logic                  rst_n,

	input  logic                  ex_valid,
	input  logic                  ex_rom,
	input  logic [`ZX_PAGE_W-1:0] ex_page,
	input  logic [`ZX_OFS_W-1:0]  ex_ofs,

	output logic                  phys_valid,
	output logic [`ZX_PHYS_W-1:0] phys_addr,
	output logic                  phys_rom
);

	logic [`ZX_PAGE_W-1:0]  rom_page;
	logic [`ZX_PAGE_W-1:0]  eff_page;
	logic [`ZX_PHYS_W-1:0]  addr_nxt;

	////////////////////////////////////////
	// address forming
	////////////////////////////////////////

	// rom chip only decodes the low page bits
	assign rom_page = {{(`ZX_PAGE_W-`ZX_ROMPG_W){1'b0}}, ex_page[`ZX_ROMPG_W-1:0]};

	assign eff_page = ex_rom ? rom_page : ex_page;

	assign addr_nxt = {eff_page, ex_ofs};

	////////////////////////////////////////
	// output registers
	////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			phys_valid <= 1'b0;
		else
			phys_valid <= ex_valid;
	end

	// hold the last result between lookups
	always_ff @(posedge fclk)
	begin
		if (ex_valid)
		begin
			phys_addr <= addr_nxt;
			phys_rom  <= ex_rom;
		end
	end

endmodule

// File: source/port_decode.sv
`timescale 1ns/1ps
`include "zx_params.svh"

module port_decode (
	input  logic                  fclk,
	input  logic                  rst_n,

	input  logic                  io_wr,
	input  logic                  mem_rd,
	input  logic [`ZX_ADDR_W-1:0] za,
	input  logic [`ZX_DATA_W-1:0] zd,

	output zx_pkg::req_kind_t     dec_kind,
	output zx_pkg::win_t          dec_win,
	output logic [`ZX_OFS_W-1:0]  dec_ofs,
	output logic [`ZX_DATA_W-1:0] dec_data
);

	logic [7:0] port_lo;

	logic is_fe;
	logic is_7ffd;
	logic is_f7;
	logic is_77;

	zx_pkg::req_kind_t kind_nxt;

	////////////////////////////////////////
	// port address matching
	////////////////////////////////////////

	assign port_lo = za[7:0];

	// FE is any even address
	assign is_fe = ~za[0];

	// partial pentagon decode: a0=1, a1=0, a15=0
	assign is_7ffd = za[0] & ~za[1] & ~za[`ZX_ADDR_W-1];

	// full low byte match, a1 is set for both so no overlap with 7FFD
	assign is_f7 = (port_lo == `ZX_PORT_F7);
	assign is_77 = (port_lo == `ZX_PORT_77);

	always_comb
	begin
		kind_nxt = zx_pkg::req_none;

		if (mem_rd)
		begin
			kind_nxt = zx_pkg::req_mem;
		end
		else if (io_wr)
		begin
			if (is_fe)
				kind_nxt = zx_pkg::req_fe;
			else if (is_7ffd)
				kind_nxt = zx_pkg::req_7ffd;
			else if (is_f7)
				kind_nxt = zx_pkg::req_f7;
			else if (is_77)
				kind_nxt = zx_pkg::req_77;
			// unmatched ports fall through as none
		end
	end

	////////////////////////////////////////
	// decode stage registers
	////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			dec_kind <= zx_pkg::req_none;
		else
			dec_kind <= kind_nxt;
	end

	// window is a15:a14 both for lookups and for F7 writes
	always_ff @(posedge fclk)
	begin
		if (io_wr || mem_rd)
		begin
			dec_win  <= za[`ZX_ADDR_W-1 -: 2];
			dec_ofs  <= za[`ZX_OFS_W-1:0];
			dec_data <= zd;
		end
	end

endmodule

// File: source/zx_pager_top.sv
`timescale 1ns/1ps
`include "zx_params.svh"

module zx_pager_top (
	input  logic                    fclk,
	input  logic                    rst_n,

	input  logic                    io_wr,
	input  logic                    mem_rd,
	input  logic [`ZX_ADDR_W-1:0]   za,
	input  logic [`ZX_DATA_W-1:0]   zd,

	output logic                    phys_valid,
	output logic [`ZX_PHYS_W-1:0]   phys_addr,
	output logic                    phys_rom,

	output logic [`ZX_BORDER_W-1:0] border,
	output logic                    beep
);

	// decode to pager
	zx_pkg::req_kind_t      dec_kind;
	zx_pkg::win_t           dec_win;
	logic [`ZX_OFS_W-1:0]   dec_ofs;
	logic [`ZX_DATA_W-1:0]  dec_data;

	// pager to address map
	logic                   ex_valid;
	logic                   ex_rom;
	logic [`ZX_PAGE_W-1:0]  ex_page;
	logic [`ZX_OFS_W-1:0]   ex_ofs;

	port_decode u_port_decode (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.io_wr    (io_wr),
		.mem_rd   (mem_rd),
		.za       (za),
		.zd       (zd),
		.dec_kind (dec_kind),
		.dec_win  (dec_win),
		.dec_ofs  (dec_ofs),
		.dec_data (dec_data)
	);

	pager_bank u_pager_bank (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.dec_kind (dec_kind),
		.dec_win  (dec_win),
		.dec_ofs  (dec_ofs),
		.dec_data (dec_data),
		.ex_valid (ex_valid),
		.ex_rom   (ex_rom),
		.ex_page  (ex_page),
		.ex_ofs   (ex_ofs),
		.border   (border),
		.beep     (beep)
	);

	phys_map u_phys_map (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.ex_valid   (ex_valid),
		.ex_rom     (ex_rom),
		.ex_page    (ex_page),
		.ex_ofs     (ex_ofs),
		.phys_valid (phys_valid),
		.phys_addr  (phys_addr),
		.phys_rom   (phys_rom)
	);

endmodule

// File: source/zx_params.svh
`ifndef ZX_PARAMS_SVH
`define ZX_PARAMS_SVH

// z80 side bus widths
`define ZX_ADDR_W 16
`define ZX_DATA_W 8

// 16K window offset and page numbers
`define ZX_OFS_W 14
`define ZX_PAGE_W 7
`define ZX_ROMPG_W 5

// physical address is page above offset
`define ZX_PHYS_W (`ZX_PAGE_W + `ZX_OFS_W)

`define ZX_BORDER_W 3

// low address bytes of the ATM pager ports
`define ZX_PORT_F7 8'hF7
`define ZX_PORT_77 8'h77

// fixed pentagon pages for the middle windows
`define ZX_PENT_WIN1_PAGE 5
`define ZX_PENT_WIN2_PAGE 2

`endif

// File: source/zx_pkg.sv
package zx_pkg;

	////////////////////////////////////////
	// decoded bus operation
	////////////////////////////////////////

	// one value per kind of strobe that survives decoding;
	// six kinds need three bits
	typedef enum logic [2:0]
	{
		req_none = 3'd0,
		req_mem  = 3'd1,
		req_7ffd = 3'd2,
		req_f7   = 3'd3,
		req_77   = 3'd4,
		req_fe   = 3'd5
	} req_kind_t;

	////////////////////////////////////////
	// memory window index
	////////////////////////////////////////

	// a15:a14 of the z80 address, four 16K windows
	typedef logic [1:0] win_t;

endpackage

// File: tb/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic fclk
);

	// free running, starts low
	initial
	begin
		fclk = 1'b0;
		forever
			#(PERIOD_NS / 2.0) fclk = ~fclk;
	end

endmodule

// File: tb/tb_zx_pager.sv
`timescale 1ns/1ps
`include "zx_params.svh"

module tb_zx_pager;

	localparam int RESET_CYCLES = 10;
	localparam int N_7FFD_OPEN = 24;
	localparam int N_7FFD_LOCKED = 12;
	localparam int N_F7 = 48;
	localparam int N_FE = 16;
	localparam int N_MIX = 240;

	// every driven cycle of all phases, both resets included
	localparam int N_OPS = 2 * (RESET_CYCLES + 1) + 4 + 3 * N_7FFD_OPEN + 3
		+ 3 * N_7FFD_LOCKED + 1 + 2 * N_F7 + 5 + 3 * N_FE + N_MIX + 6;
	localparam int CYCLE_LIMIT = N_OPS + 50;

	// port kinds for address building
	localparam int K_FE = 0;
	localparam int K_7FFD = 1;
	localparam int K_F7 = 2;
	localparam int K_77 = 3;

	logic                    fclk;
	logic                    rst_n;
	logic                    io_wr;
	logic                    mem_rd;
	logic [`ZX_ADDR_W-1:0]   za;
	logic [`ZX_DATA_W-1:0]   zd;
	logic                    phys_valid;
	logic [`ZX_PHYS_W-1:0]   phys_addr;
	logic                    phys_rom;
	logic [`ZX_BORDER_W-1:0] border;
	logic                    beep;

	int seed;
	int cyc = 0;

	// reference model of the paging state
	logic [2:0]              m_bank;
	logic                    m_rom_sel;
	logic                    m_lock;
	logic [`ZX_PAGE_W-1:0]   m_page [4];
	logic [3:0]              m_ram;
	logic                    m_en;
	logic [`ZX_BORDER_W-1:0] m_border;
	logic                    m_beep;

	// expected lookup results, oldest first
	logic [`ZX_PHYS_W-1:0] q_addr [$];
	logic                  q_rom [$];
	int                    q_cyc [$];

	clock_gen u_clock_gen (
		.fclk (fclk)
	);

	zx_pager_top dut0 (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.io_wr      (io_wr),
		.mem_rd     (mem_rd),
		.za         (za),
		.zd         (zd),
		.phys_valid (phys_valid),
		.phys_addr  (phys_addr),
		.phys_rom   (phys_rom),
		.border     (border),
		.beep       (beep)
	);

	bind zx_pager_top zx_pager_assertions u_assertions (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.io_wr      (io_wr),
		.mem_rd     (mem_rd),
		.phys_valid (phys_valid),
		.phys_addr  (phys_addr),
		.phys_rom   (phys_rom)
	);

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [15:0] rnd();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	function automatic logic [15:0] win_addr(input logic [1:0] w);
		logic [15:0] a;
		a = rnd();
		a[15:14] = w;
		return a;
	endfunction

	// random address that hits the given port, any other kind stays random
	function automatic logic [15:0] port_addr(input int kind, input logic [1:0] w);
		logic [15:0] a;
		a = rnd();
		if (kind == K_FE)
			a[0] = 1'b0;
		else if (kind == K_7FFD)
		begin
			a[15] = 1'b0;
			a[1:0] = 2'b01;
		end
		else if (kind == K_F7)
		begin
			a[15:14] = w;
			a[7:0] = `ZX_PORT_F7;
		end
		else if (kind == K_77)
			a[7:0] = `ZX_PORT_77;
		return a;
	endfunction

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	task automatic model_reset();
		m_bank = '0;
		m_rom_sel = 1'b0;
		m_lock = 1'b0;
		m_ram = '0;
		m_en = 1'b0;
		m_border = '0;
		m_beep = 1'b0;
		for (int i = 0; i < 4; i++)
			m_page[i] = '0;
	endtask

	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		if (!a[0])
		begin
			m_border = d[2:0];
			m_beep = d[4];
		end
		else if (!a[1] && !a[15])
		begin
			if (!m_lock)
			begin
				m_bank = d[2:0];
				m_rom_sel = d[4];
				m_lock = d[5];
			end
		end
		else if (a[7:0] == `ZX_PORT_F7)
		begin
			m_page[a[15:14]] = d[6:0];
			m_ram[a[15:14]] = d[7];
		end
		else if (a[7:0] == `ZX_PORT_77)
			m_en = d[0];
	endtask

	task automatic model_lookup(input logic [15:0] a);
		logic [1:0] w;
		logic [6:0] page;
		logic       ram;
		w = a[15:14];
		if (m_en)
		begin
			page = m_page[w];
			ram = m_ram[w];
		end
		else
		begin
			ram = (w != 2'd0);
			if (w == 2'd0)
				page = {6'd0, m_rom_sel};
			else if (w == 2'd1)
				page = 7'(`ZX_PENT_WIN1_PAGE);
			else if (w == 2'd2)
				page = 7'(`ZX_PENT_WIN2_PAGE);
			else
				page = {4'd0, m_bank};
		end
		if (ram)
			q_addr.push_back({page, a[13:0]});
		else
			q_addr.push_back({2'b00, page[4:0], a[13:0]});
		q_rom.push_back(!ram);
		// sampled on the next edge, then three stages
		q_cyc.push_back(cyc + 3);
	endtask

	////////////////////////////////////////
	// bus driving on the falling edge
	////////////////////////////////////////

	task automatic drive_idle();
		@(negedge fclk);
		io_wr = 1'b0;
		mem_rd = 1'b0;
	endtask

	task automatic drive_write(input logic [15:0] a, input logic [7:0] d);
		@(negedge fclk);
		io_wr = 1'b1;
		mem_rd = 1'b0;
		za = a;
		zd = d;
		model_write(a, d);
	endtask

	task automatic drive_lookup(input logic [15:0] a);
		@(negedge fclk);
		io_wr = 1'b0;
		mem_rd = 1'b1;
		za = a;
		model_lookup(a);
	endtask

	task automatic apply_reset();
		@(negedge fclk);
		rst_n = 1'b0;
		io_wr = 1'b0;
		mem_rd = 1'b0;
		model_reset();
		repeat (RESET_CYCLES) @(negedge fclk);
		rst_n = 1'b1;
	endtask

	task automatic drain();
		while (q_addr.size() != 0)
			drive_idle();
	endtask

	////////////////////////////////////////
	// result monitor and cycle limit
	////////////////////////////////////////

	always @(negedge fclk)
	begin
		if (rst_n && phys_valid)
		begin
			if (q_addr.size() == 0)
			begin
				$display("phys_valid went high with no lookup outstanding");
				$display("SIMULATION FAILED");
				$fatal(1, "unexpected result");
			end
			else
			begin
				check("phys_addr", 32'(phys_addr), 32'(q_addr.pop_front()));
				check("phys_rom", 32'(phys_rom), 32'(q_rom.pop_front()));
				check("phys_valid cycle", cyc, q_cyc.pop_front());
			end
		end
	end

	always @(posedge fclk)
	begin
		cyc = cyc + 1;
		if (cyc > CYCLE_LIMIT)
		begin
			$display("run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		logic [7:0]              d;
		logic [15:0]             sel;
		logic [`ZX_BORDER_W-1:0] prev_border;
		logic                    prev_beep;

		seed = 32'hc75;
		rst_n = 1'b0;
		io_wr = 1'b0;
		mem_rd = 1'b0;
		za = '0;
		zd = '0;
		apply_reset();

		// pentagon defaults after reset
		for (int w = 0; w < 4; w++)
			drive_lookup(win_addr(2'(w)));
		drain();
		check("border", 32'(border), 32'(0));
		check("beep", 32'(beep), 32'(0));

		// 7FFD bank and rom select, then the lock
		for (int i = 0; i < N_7FFD_OPEN; i++)
		begin
			d = 8'(rnd());
			d[5] = 1'b0;
			drive_write(port_addr(K_7FFD, 2'd0), d);
			drive_lookup(win_addr(2'd0));
			drive_lookup(win_addr(2'd3));
		end
		d = 8'(rnd());
		d[5] = 1'b1;
		drive_write(port_addr(K_7FFD, 2'd0), d);
		drive_lookup(win_addr(2'd0));
		drive_lookup(win_addr(2'd3));
		for (int i = 0; i < N_7FFD_LOCKED; i++)
		begin
			drive_write(port_addr(K_7FFD, 2'd0), 8'(rnd()));
			drive_lookup(win_addr(2'd0));
			drive_lookup(win_addr(2'd3));
		end
		drain();

		// ATM window pagers
		drive_write(port_addr(K_77, 2'd0), 8'h01);
		for (int i = 0; i < N_F7; i++)
		begin
			drive_write(port_addr(K_F7, 2'(rnd())), 8'(rnd()));
			drive_lookup(win_addr(2'(rnd())));
		end
		drive_write(port_addr(K_77, 2'd0), 8'h00);
		for (int w = 0; w < 4; w++)
			drive_lookup(win_addr(2'(w)));
		drain();

		// border and beep land on the second edge
		for (int i = 0; i < N_FE; i++)
		begin
			prev_border = m_border;
			prev_beep = m_beep;
			drive_write(port_addr(K_FE, 2'd0), 8'(rnd()));
			drive_idle();
			check("border", 32'(border), 32'(prev_border));
			check("beep", 32'(beep), 32'(prev_beep));
			drive_idle();
			check("border", 32'(border), 32'(m_border));
			check("beep", 32'(beep), 32'(m_beep));
		end

		// fresh reset frees 7FFD, then mixed traffic
		apply_reset();
		for (int i = 0; i < N_MIX; i++)
		begin
			sel = rnd();
			if (sel[0])
				drive_lookup(rnd());
			else
				drive_write(port_addr(int'(sel[3:1]) % 5, sel[5:4]), 8'(rnd()));
		end

		repeat (6) drive_idle();
		check("border", 32'(border), 32'(m_border));
		check("beep", 32'(beep), 32'(m_beep));
		if (q_addr.size() != 0)
		begin
			$display("%0d lookups never returned a result", q_addr.size());
			$display("SIMULATION FAILED");
			$fatal(1, "missing results");
		end
		else
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// File: tb/zx_pager_assertions.sv
`timescale 1ns/1ps
`include "zx_params.svh"

module zx_pager_assertions (
	input logic                  fclk,
	input logic                  rst_n,
	input logic                  io_wr,
	input logic                  mem_rd,
	input logic                  phys_valid,
	input logic [`ZX_PHYS_W-1:0] phys_addr,
	input logic                  phys_rom
);

	// z80 side issues one strobe per cycle at most
	strobe_exclusive: assert property (@(posedge fclk) disable iff (!rst_n)
		!(io_wr && mem_rd))
		else $error("io_wr and mem_rd high in the same cycle");

	// decode, pager and map stages, one register each
	valid_latency: assert property (@(posedge fclk) disable iff (!rst_n)
		phys_valid == $past(mem_rd, 3))
		else $error("phys_valid does not follow mem_rd by 3 cycles");

	// rom chip sees only the low page bits
	rom_page_width: assert property (@(posedge fclk) disable iff (!rst_n)
		phys_rom |-> (phys_addr[`ZX_PHYS_W-1:`ZX_OFS_W+`ZX_ROMPG_W] == '0))
		else $error("rom address has bits set above the rom page width");

endmodule

// File: vlog.f
+incdir+source
source/zx_pkg.sv
source/port_decode.sv
source/pager_bank.sv
source/phys_map.sv
source/zx_pager_top.sv
tb/clock_gen.sv
tb/zx_pager_assertions.sv
tb/tb_zx_pager.sv
